/* rtl/revo_config.svh */
`ifndef REVO_CONFIG_SVH
`define REVO_CONFIG_SVH

// --------------------------------------------------
// Widths
// --------------------------------------------------
// Samples per clock127 cycle
`define REVO_WORD_WIDTH 4
`define PHASE_SEL_WIDTH 2
// Bits sent per cycle on the forwarded link
`define SYMBOL_WIDTH 2

// --------------------------------------------------
// Lock patterns, one per clock phase
// --------------------------------------------------
`define LOCK_PAT_PHASE0 4'b1110
`define LOCK_PAT_PHASE1 4'b1100
`define LOCK_PAT_PHASE2 4'b1000
`define LOCK_PAT_PHASE3 4'b1111

// Forwarded-clock symbols
`define SYMBOL_IDLE_CLOCK 2'b01
`define SYMBOL_TRIGGER 2'b11
`define SYMBOL_RESET 2'b00

`endif

/* rtl/revo_pkg.sv */
`default_nettype none

`include "revo_config.svh"

package revo_pkg;

	// --------------------------------------------------
	// Sampled marker words
	// --------------------------------------------------

	// One deserialized sample word, bit 3 is the earliest sample
	typedef logic [`REVO_WORD_WIDTH-1:0] revo_word_t;

	// --------------------------------------------------
	// Phase alignment
	// --------------------------------------------------

	// Index of the clock phase the marker lined up with
	typedef logic [`PHASE_SEL_WIDTH-1:0] phase_sel_t;

endpackage

`default_nettype wire

/* rtl/link_pkg.sv */
`default_nettype none

`include "revo_config.svh"

package link_pkg;

	// --------------------------------------------------
	// Forwarded link
	// --------------------------------------------------

	// Two half-cycle bits per clock127 cycle, bit 0 goes out first
	typedef logic [`SYMBOL_WIDTH-1:0] link_symbol_t;

	// --------------------------------------------------
	// Lock sequencing
	// --------------------------------------------------

	// Searching for the first marker, settling one cycle, then running
	typedef enum logic [1:0] {
		LOCK_SEARCHING = 2'd0,
		LOCK_SETTLING  = 2'd1,
		LOCK_RUNNING   = 2'd2
	} lock_state_t;

endpackage

`default_nettype wire

/* rtl/revo_edge_detect.sv */
`timescale 1ns/1ns
`default_nettype none

module revo_edge_detect (
	input  wire logic               clock127,
	input  wire logic               pll_127_127_locked,
	input  wire revo_pkg::revo_word_t revo_word,
	output revo_pkg::revo_word_t    revo_pulse
);

	// Word seen on the previous edge
	revo_pkg::revo_word_t prev_word;

	// --------------------------------------------------
	// Per-bit rising edges
	// --------------------------------------------------
	always_ff @(posedge clock127 or negedge pll_127_127_locked) begin
		if (!pll_127_127_locked) begin
			prev_word  <= '0;
			revo_pulse <= '0;
		end else begin
			prev_word  <= revo_word;
			// A sample bit that just went from 0 to 1
			revo_pulse <= revo_word & ~prev_word;
		end
	end

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------

	// Any pulse bit must trace back to a word two edges ago with that bit low
	property p_pulse_follows_low;
		@(posedge clock127) disable iff (!pll_127_127_locked)
		($past(pll_127_127_locked, 2) && (|revo_pulse))
			|-> ((revo_pulse & $past(revo_word, 2)) == '0);
	endproperty

	a_pulse_follows_low: assert property (p_pulse_follows_low)
		else $error("revo_pulse bit set without a preceding low sample");

endmodule

`default_nettype wire

/* rtl/revo_phase_lock.sv */
`timescale 1ns/1ns
`default_nettype none

`include "revo_config.svh"

module revo_phase_lock (
	input  wire logic                 clock127,
	input  wire logic                 pll_127_127_locked,
	input  wire revo_pkg::revo_word_t revo_pulse,
	output logic                      phase_locked,
	output revo_pkg::phase_sel_t      phase_select,
	output revo_pkg::revo_word_t      lock_pattern,
	output logic                      encoder_enable
);

	link_pkg::lock_state_t state;

	// Decoded view of the current pulse word
	logic                 pattern_match;
	revo_pkg::phase_sel_t pattern_select;

	// --------------------------------------------------
	// Pattern table
	// --------------------------------------------------
	// Where the marker edge fell inside the word tells us the phase.
	// Anything else, including an empty word, is not a usable marker
	always_comb begin
		pattern_match  = 1'b1;
		pattern_select = revo_pkg::phase_sel_t'(0);
		case (revo_pulse)
			`LOCK_PAT_PHASE0: begin
				pattern_select = revo_pkg::phase_sel_t'(0);
			end
			`LOCK_PAT_PHASE1: begin
				pattern_select = revo_pkg::phase_sel_t'(1);
			end
			`LOCK_PAT_PHASE2: begin
				pattern_select = revo_pkg::phase_sel_t'(2);
			end
			`LOCK_PAT_PHASE3: begin
				pattern_select = revo_pkg::phase_sel_t'(3);
			end
			default: begin
				pattern_match = 1'b0;
			end
		endcase
	end

	// --------------------------------------------------
	// Lock FSM
	// --------------------------------------------------
	always_ff @(posedge clock127 or negedge pll_127_127_locked) begin
		if (!pll_127_127_locked) begin
			state        <= link_pkg::LOCK_SEARCHING;
			phase_select <= revo_pkg::phase_sel_t'(0);
			lock_pattern <= '0;
		end else begin
			case (state)
				link_pkg::LOCK_SEARCHING: begin
					// First match wins, later ones are ignored until reset
					if (pattern_match) begin
						state        <= link_pkg::LOCK_SETTLING;
						phase_select <= pattern_select;
						lock_pattern <= revo_pulse;
					end
				end
				link_pkg::LOCK_SETTLING: begin
					// One quiet cycle so the locking pulse never reaches the encoder
					state <= link_pkg::LOCK_RUNNING;
				end
				link_pkg::LOCK_RUNNING: begin
					state <= link_pkg::LOCK_RUNNING;
				end
				default: begin
					state <= link_pkg::LOCK_SEARCHING;
				end
			endcase
		end
	end

	// Status decoded straight from the state register
	assign phase_locked   = (state != link_pkg::LOCK_SEARCHING);
	assign encoder_enable = (state == link_pkg::LOCK_RUNNING);

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------

	// Once locked, the phase choice holds until the next reset
	property p_select_held;
		@(posedge clock127) disable iff (!pll_127_127_locked)
		phase_locked |=> (phase_locked && $stable(phase_select) && $stable(lock_pattern));
	endproperty

	a_select_held: assert property (p_select_held)
		else $error("phase_select or lock_pattern moved while locked");

endmodule

`default_nettype wire

/* rtl/trigger_encoder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "revo_config.svh"

module trigger_encoder (
	input  wire logic                 clock127,
	input  wire logic                 pll_127_127_locked,
	input  wire logic                 encoder_enable,
	input  wire revo_pkg::revo_word_t revo_pulse,
	output logic                      trg,
	output link_pkg::link_symbol_t    link_symbol
);

	// Any marker edge in the word, held as long as edges keep coming
	logic long_trg;
	// long_trg one cycle later, for edge detection
	logic long_trg_d;
	// Single-cycle version of long_trg
	logic short_trg;

	// --------------------------------------------------
	// Trigger shaping
	// --------------------------------------------------
	always_ff @(posedge clock127 or negedge pll_127_127_locked) begin
		if (!pll_127_127_locked) begin
			long_trg   <= 1'b0;
			long_trg_d <= 1'b0;
			short_trg  <= 1'b0;
			trg        <= 1'b0;
		end else if (!encoder_enable) begin
			// Held clear until the phase lock has settled
			long_trg   <= 1'b0;
			long_trg_d <= 1'b0;
			short_trg  <= 1'b0;
			trg        <= 1'b0;
		end else begin
			long_trg   <= |revo_pulse;
			long_trg_d <= long_trg;
			short_trg  <= long_trg & ~long_trg_d;
			trg        <= short_trg;
		end
	end

	// --------------------------------------------------
	// Forwarded-clock symbol
	// --------------------------------------------------
	// Normally the link toggles like a clock, a trigger holds it high
	// for the whole cycle, and it stays flat while disabled
	always_comb begin
		if (!encoder_enable) begin
			link_symbol = `SYMBOL_RESET;
		end else if (trg) begin
			link_symbol = `SYMBOL_TRIGGER;
		end else begin
			link_symbol = `SYMBOL_IDLE_CLOCK;
		end
	end

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------

	// A marker, however long, is sent as a single trigger cycle
	property p_trg_single;
		@(posedge clock127) disable iff (!pll_127_127_locked)
		trg |=> !trg;
	endproperty

	a_trg_single: assert property (p_trg_single)
		else $error("trg high on two consecutive cycles");

	// No trigger leaves before the lock FSM reaches the running state
	property p_trg_needs_enable;
		@(posedge clock127) disable iff (!pll_127_127_locked)
		!encoder_enable |-> !trg;
	endproperty

	a_trg_needs_enable: assert property (p_trg_needs_enable)
		else $error("trg high while encoder_enable is low");

endmodule

`default_nettype wire

/* rtl/revo_encoder_top.sv */
`timescale 1ns/1ns
`default_nettype none

module revo_encoder_top (
	input  wire logic                 clock127,
	input  wire logic                 pll_127_127_locked,
	input  wire revo_pkg::revo_word_t revo_word,
	output logic                      trg,
	output link_pkg::link_symbol_t    link_symbol,
	output logic                      phase_locked,
	output revo_pkg::phase_sel_t      phase_select,
	output revo_pkg::revo_word_t      lock_pattern
);

	// Edge pulses shared by the lock and the encoder
	revo_pkg::revo_word_t revo_pulse;
	logic                 encoder_enable;

	// --------------------------------------------------
	// Stage 1, sample edges
	// --------------------------------------------------
	revo_edge_detect u_edge_detect (
		.clock127           (clock127),
		.pll_127_127_locked (pll_127_127_locked),
		.revo_word          (revo_word),
		.revo_pulse         (revo_pulse)
	);

	// --------------------------------------------------
	// Stage 2, phase capture
	// --------------------------------------------------
	revo_phase_lock u_phase_lock (
		.clock127           (clock127),
		.pll_127_127_locked (pll_127_127_locked),
		.revo_pulse         (revo_pulse),
		.phase_locked       (phase_locked),
		.phase_select       (phase_select),
		.lock_pattern       (lock_pattern),
		.encoder_enable     (encoder_enable)
	);

	// --------------------------------------------------
	// Stage 3, trigger onto the link
	// --------------------------------------------------
	trigger_encoder u_trigger_encoder (
		.clock127           (clock127),
		.pll_127_127_locked (pll_127_127_locked),
		.encoder_enable     (encoder_enable),
		.revo_pulse         (revo_pulse),
		.trg                (trg),
		.link_symbol        (link_symbol)
	);

endmodule

`default_nettype wire

/* tb/revo_encoder_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module revo_encoder_tb;

	// --------------------------------------------------
	// Run parameters
	// --------------------------------------------------
	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_ROWS     = 10;
	localparam int NUM_RESETS   = 7;
	// Words per table row, first word in the top nibble
	localparam int ROW_LEN      = 8;
	localparam int RANDOM_WORDS = 200;
	localparam int TOTAL_CYCLES = NUM_ROWS * ROW_LEN + RANDOM_WORDS;
	localparam int WATCHDOG_NS  = 2 * TOTAL_CYCLES * CLK_PERIOD
		+ NUM_RESETS * RESET_CYCLES * CLK_PERIOD;

	// Forwarded-clock symbols
	localparam logic [1:0] SYM_RESET = 2'b00;
	localparam logic [1:0] SYM_IDLE  = 2'b01;
	localparam logic [1:0] SYM_TRIG  = 2'b11;

	// Lock states of the reference model
	localparam int ST_SEARCH = 0;
	localparam int ST_SETTLE = 1;
	localparam int ST_RUN    = 2;

	logic       clock127;
	logic       pll_127_127_locked;
	logic [3:0] revo_word;
	logic       trg;
	logic [1:0] link_symbol;
	logic       phase_locked;
	logic [1:0] phase_select;
	logic [3:0] lock_pattern;

	// Stimulus table
	logic        row_reset   [NUM_ROWS];
	logic [31:0] row_words   [NUM_ROWS];
	logic        row_locked  [NUM_ROWS];
	logic [1:0]  row_sel     [NUM_ROWS];
	logic [3:0]  row_pat     [NUM_ROWS];
	// Bit i is the expected trg after the edge of word i
	logic [7:0]  row_trg     [NUM_ROWS];

	// Reference model state
	logic [3:0] m_prev;
	logic [3:0] m_pulse;
	int         m_state;
	logic [1:0] m_sel;
	logic [3:0] m_pat;
	logic       m_long;
	logic       m_long_d;
	logic       m_short;
	logic       m_trg;

	int error_count;
	int check_count;

	revo_encoder_top DUT (
		.clock127           (clock127),
		.pll_127_127_locked (pll_127_127_locked),
		.revo_word          (revo_word),
		.trg                (trg),
		.link_symbol        (link_symbol),
		.phase_locked       (phase_locked),
		.phase_select       (phase_select),
		.lock_pattern       (lock_pattern)
	);

	initial begin
		clock127 = 1'b0;
		forever #(CLK_PERIOD / 2) clock127 = ~clock127;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("TESTS FAILED");
		$finish;
	end

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAILED %s: actual 0x%0h, expected 0x%0h at %0t ns",
				name, actual, expected, $time);
		end
	endtask

	task automatic set_row(input int r, input logic rst, input logic [31:0] words,
		input logic locked, input logic [1:0] sel, input logic [3:0] pat,
		input logic [7:0] exp_trg);
		row_reset[r]  = rst;
		row_words[r]  = words;
		row_locked[r] = locked;
		row_sel[r]    = sel;
		row_pat[r]    = pat;
		row_trg[r]    = exp_trg;
	endtask

	// Phase index for a marker pattern, -1 when it is not a lock pattern
	function automatic int phase_of_pattern(input logic [3:0] p);
		case (p)
			4'b1110: return 0;
			4'b1100: return 1;
			4'b1000: return 2;
			4'b1111: return 3;
			default: return -1;
		endcase
	endfunction

	function automatic logic [1:0] expected_symbol();
		if (m_state != ST_RUN)
			return SYM_RESET;
		else if (m_trg)
			return SYM_TRIG;
		else
			return SYM_IDLE;
	endfunction

	task automatic clear_model();
		m_prev   = '0;
		m_pulse  = '0;
		m_state  = ST_SEARCH;
		m_sel    = '0;
		m_pat    = '0;
		m_long   = 1'b0;
		m_long_d = 1'b0;
		m_short  = 1'b0;
		m_trg    = 1'b0;
	endtask

	// Model state after the next rising edge, given the word applied now
	task automatic advance_model(input logic [3:0] w);
		int ph;
		ph = phase_of_pattern(m_pulse);
		if (m_state == ST_RUN) begin
			m_trg    = m_short;
			m_short  = m_long & ~m_long_d;
			m_long_d = m_long;
			m_long   = |m_pulse;
		end else begin
			m_trg    = 1'b0;
			m_short  = 1'b0;
			m_long_d = 1'b0;
			m_long   = 1'b0;
		end
		if (m_state == ST_SEARCH && ph >= 0) begin
			m_state = ST_SETTLE;
			m_sel   = ph[1:0];
			m_pat   = m_pulse;
		end else if (m_state == ST_SETTLE) begin
			m_state = ST_RUN;
		end
		m_pulse = w & ~m_prev;
		m_prev  = w;
	endtask

	task automatic apply_reset();
		pll_127_127_locked = 1'b0;
		revo_word          = '0;
		repeat (RESET_CYCLES) @(negedge clock127);
		pll_127_127_locked = 1'b1;
		clear_model();
		check_value("trg", trg, 0);
		check_value("phase_locked", phase_locked, 0);
		check_value("phase_select", phase_select, 0);
		check_value("lock_pattern", lock_pattern, 0);
		check_value("link_symbol", link_symbol, SYM_RESET);
	endtask

	// Drive one word at the falling edge, check one edge later
	task automatic apply_word(input logic [3:0] w);
		revo_word = w;
		advance_model(w);
		@(negedge clock127);
		check_value("trg", trg, m_trg);
		check_value("link_symbol", link_symbol, expected_symbol());
		check_value("phase_locked", phase_locked, (m_state != ST_SEARCH));
		check_value("phase_select", phase_select, m_sel);
		check_value("lock_pattern", lock_pattern, m_pat);
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		logic [3:0] w;
		int unused_seed;
		pll_127_127_locked = 1'b0;
		revo_word          = '0;
		error_count        = 0;
		check_count        = 0;
		unused_seed        = $urandom(32'hebc59bc2);

		// Lock patterns, each from a fresh reset
		set_row(0, 1'b1, 32'h0E00_0000, 1'b1, 2'd0, 4'hE, 8'h00);
		set_row(1, 1'b1, 32'h0C00_0000, 1'b1, 2'd1, 4'hC, 8'h00);
		set_row(2, 1'b1, 32'h0800_0000, 1'b1, 2'd2, 4'h8, 8'h00);
		set_row(3, 1'b1, 32'h0F00_0000, 1'b1, 2'd3, 4'hF, 8'h00);
		// Not a lock pattern
		set_row(4, 1'b1, 32'h0600_0000, 1'b0, 2'd0, 4'h0, 8'h00);
		set_row(5, 1'b1, 32'h0100_0000, 1'b0, 2'd0, 4'h0, 8'h00);
		// Lock, then hold against later patterns
		set_row(6, 1'b1, 32'h0C00_0000, 1'b1, 2'd1, 4'hC, 8'h00);
		set_row(7, 1'b0, 32'h0E0F_0000, 1'b1, 2'd1, 4'hC, 8'h50);
		// Single marker, then a sustained one
		set_row(8, 1'b0, 32'h0500_0000, 1'b1, 2'd1, 4'hC, 8'h10);
		set_row(9, 1'b0, 32'h08CE_F000, 1'b1, 2'd1, 4'hC, 8'h10);

		for (int r = 0; r < NUM_ROWS; r++) begin
			if (row_reset[r])
				apply_reset();
			for (int i = 0; i < ROW_LEN; i++) begin
				apply_word(row_words[r][31 - 4 * i -: 4]);
				check_value("trg", trg, row_trg[r][i]);
			end
			check_value("phase_locked", phase_locked, row_locked[r]);
			check_value("phase_select", phase_select, row_sel[r]);
			check_value("lock_pattern", lock_pattern, row_pat[r]);
		end

		// Random words on the locked link
		for (int n = 0; n < RANDOM_WORDS; n++) begin
			w = 4'($urandom() & 32'hF);
			apply_word(w);
		end

		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+rtl
rtl/revo_pkg.sv
rtl/link_pkg.sv
rtl/revo_edge_detect.sv
rtl/revo_phase_lock.sv
rtl/trigger_encoder.sv
rtl/revo_encoder_top.sv
tb/revo_encoder_tb.sv

/* Bender.yml */
package:
  name: revo_encoder

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/revo_pkg.sv
      - rtl/link_pkg.sv
      - rtl/revo_edge_detect.sv
      - rtl/revo_phase_lock.sv
      - rtl/trigger_encoder.sv
      - rtl/revo_encoder_top.sv
  - target: simulation
    files:
      - tb/revo_encoder_tb.sv
